// ==== bench/tb_csr_unit.sv ====
`timescale 1ns/100ps

module tb_csr_unit;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  localparam int N_OPS        = 200;
  localparam int N_TRAPS      = 20;
  localparam int N_ILLEGAL    = 20;
  localparam int N_COMBO      = 20;
  // every stimulus call takes one clock
  localparam int TEST_CYCLES  = RESET_CYCLES + 6 + N_OPS * 2 + N_TRAPS * 9
                                + N_ILLEGAL * 3 + N_COMBO * 2 + 4;

  logic                                 clk;
  logic                                 rst_n;
  logic                                 csr_valid;
  logic [rv64_csr_pkg::CSR_OP_W-1:0]   csr_op;
  logic [rv64_csr_pkg::CSR_ADDR_W-1:0] csr_addr;
  logic [rv64_csr_pkg::XLEN-1:0]       csr_src;
  logic                                 exc_valid;
  logic [rv64_csr_pkg::XLEN-1:0]       exc_cause;
  logic [rv64_csr_pkg::XLEN-1:0]       exc_pc;
  logic [rv64_csr_pkg::XLEN-1:0]       exc_tval;
  logic                                 mret;
  logic [rv64_csr_pkg::XLEN-1:0]       csr_rdata;
  logic                                 redirect;
  logic [rv64_csr_pkg::XLEN-1:0]       redirect_pc;
  logic                                 mie;

  // shadow copy of the architectural state
  logic [rv64_csr_pkg::XLEN-1:0] sh_mtvec;
  logic [rv64_csr_pkg::XLEN-1:0] sh_mepc;
  logic [rv64_csr_pkg::XLEN-1:0] sh_mcause;
  logic [rv64_csr_pkg::XLEN-1:0] sh_mtval;
  logic                          sh_mie;
  logic                          sh_mpie;

  logic [rv64_csr_pkg::XLEN-1:0]       exp_rdata;
  logic [rv64_csr_pkg::XLEN-1:0]       exp_pc;
  logic                                 exp_redirect;
  logic                                 exp_mie;
  logic [rv64_csr_pkg::CSR_OP_W-1:0]   op_sel;
  logic [rv64_csr_pkg::CSR_ADDR_W-1:0] addr_sel;
  logic [31:0]                          rnd;
  int                                   seed;

  rv64_csr_unit dut0 (
    .clk           (clk),
    .rst_n_i       (rst_n),
    .csr_valid_i   (csr_valid),
    .csr_op_i      (csr_op),
    .csr_addr_i    (csr_addr),
    .csr_src_i     (csr_src),
    .exc_valid_i   (exc_valid),
    .exc_cause_i   (exc_cause),
    .exc_pc_i      (exc_pc),
    .exc_tval_i    (exc_tval),
    .mret_i        (mret),
    .csr_rdata_o   (csr_rdata),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc),
    .mie_o         (mie)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic csr_implemented(input logic [rv64_csr_pkg::CSR_ADDR_W-1:0] addr);
    case (addr)
      rv64_csr_pkg::CSR_MSTATUS, rv64_csr_pkg::CSR_MTVEC, rv64_csr_pkg::CSR_MEPC,
      rv64_csr_pkg::CSR_MCAUSE, rv64_csr_pkg::CSR_MTVAL: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [rv64_csr_pkg::XLEN-1:0] shadow_read(
    input logic [rv64_csr_pkg::CSR_ADDR_W-1:0] addr);
    logic [rv64_csr_pkg::XLEN-1:0] v;
    v = '0;
    case (addr)
      rv64_csr_pkg::CSR_MSTATUS: begin
        v[3] = sh_mie;
        v[7] = sh_mpie;
      end
      rv64_csr_pkg::CSR_MTVEC:  v = sh_mtvec;
      rv64_csr_pkg::CSR_MEPC:   v = sh_mepc;
      rv64_csr_pkg::CSR_MCAUSE: v = sh_mcause;
      rv64_csr_pkg::CSR_MTVAL:  v = sh_mtval;
      default: v = '0;
    endcase
    return v;
  endfunction

  // expected outputs for the inputs of this cycle, the shadow moves on to the next state
  function automatic void csr_model(output logic [rv64_csr_pkg::XLEN-1:0] rdata,
                                    output logic redir,
                                    output logic [rv64_csr_pkg::XLEN-1:0] redir_pc);
    logic [rv64_csr_pkg::XLEN-1:0] old_val;
    logic [rv64_csr_pkg::XLEN-1:0] new_val;
    logic                          illegal;
    old_val  = shadow_read(csr_addr);
    illegal  = csr_valid && !csr_implemented(csr_addr);
    rdata    = old_val;
    redir    = 1'b0;
    redir_pc = '0;
    if (exc_valid || illegal) begin
      redir     = 1'b1;
      redir_pc  = sh_mtvec;
      sh_mepc   = exc_pc;
      sh_mcause = exc_valid ? exc_cause : rv64_csr_pkg::XLEN'(2);
      sh_mtval  = exc_valid ? exc_tval : rv64_csr_pkg::XLEN'(csr_addr);
      sh_mpie   = sh_mie;
      sh_mie    = 1'b0;
    end else if (mret) begin
      redir    = 1'b1;
      redir_pc = sh_mepc;
      sh_mie   = sh_mpie;
      sh_mpie  = 1'b1;
    end else if (csr_valid) begin
      case (csr_op)
        rv64_csr_pkg::CSR_RW, rv64_csr_pkg::CSR_RWI: new_val = csr_src;
        rv64_csr_pkg::CSR_RS, rv64_csr_pkg::CSR_RSI: new_val = old_val | csr_src;
        default: new_val = old_val & ~csr_src;
      endcase
      case (csr_addr)
        rv64_csr_pkg::CSR_MSTATUS: begin
          sh_mie  = new_val[3];
          sh_mpie = new_val[7];
        end
        rv64_csr_pkg::CSR_MTVEC:  sh_mtvec  = new_val & ~64'h3; // direct mode only
        rv64_csr_pkg::CSR_MEPC:   sh_mepc   = new_val & ~64'h1;
        rv64_csr_pkg::CSR_MCAUSE: sh_mcause = new_val;
        rv64_csr_pkg::CSR_MTVAL:  sh_mtval  = new_val;
        default: ;
      endcase
    end
  endfunction

  function automatic logic [rv64_csr_pkg::XLEN-1:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic logic [rv64_csr_pkg::CSR_OP_W-1:0] rand_op();
    int unsigned k;
    k = $unsigned($random(seed)) % 6;
    case (k)
      0: return rv64_csr_pkg::CSR_RW;
      1: return rv64_csr_pkg::CSR_RS;
      2: return rv64_csr_pkg::CSR_RC;
      3: return rv64_csr_pkg::CSR_RWI;
      4: return rv64_csr_pkg::CSR_RSI;
      default: return rv64_csr_pkg::CSR_RCI;
    endcase
  endfunction

  function automatic logic [rv64_csr_pkg::CSR_ADDR_W-1:0] rand_csr();
    int unsigned k;
    k = $unsigned($random(seed)) % 5;
    case (k)
      0: return rv64_csr_pkg::CSR_MSTATUS;
      1: return rv64_csr_pkg::CSR_MTVEC;
      2: return rv64_csr_pkg::CSR_MEPC;
      3: return rv64_csr_pkg::CSR_MCAUSE;
      default: return rv64_csr_pkg::CSR_MTVAL;
    endcase
  endfunction

  function automatic logic [rv64_csr_pkg::CSR_ADDR_W-1:0] rand_unimplemented();
    logic [31:0] r;
    do begin
      r = $random(seed);
    end while (csr_implemented(r[rv64_csr_pkg::CSR_ADDR_W-1:0]));
    return r[rv64_csr_pkg::CSR_ADDR_W-1:0];
  endfunction

  // immediate forms carry a zero-extended 5-bit zimm
  function automatic logic [rv64_csr_pkg::XLEN-1:0] rand_src(
    input logic [rv64_csr_pkg::CSR_OP_W-1:0] op);
    if (op == rv64_csr_pkg::CSR_RWI || op == rv64_csr_pkg::CSR_RSI ||
        op == rv64_csr_pkg::CSR_RCI) begin
      return rand64() & 64'h1f;
    end
    return rand64();
  endfunction

  task automatic drive(input logic v, input logic [rv64_csr_pkg::CSR_OP_W-1:0] op,
                       input logic [rv64_csr_pkg::CSR_ADDR_W-1:0] addr,
                       input logic [rv64_csr_pkg::XLEN-1:0] src, input logic exc,
                       input logic [rv64_csr_pkg::XLEN-1:0] cause,
                       input logic [rv64_csr_pkg::XLEN-1:0] pc,
                       input logic [rv64_csr_pkg::XLEN-1:0] tval, input logic ret);
    @(posedge clk);
    csr_valid <= v;
    csr_op    <= op;
    csr_addr  <= addr;
    csr_src   <= src;
    exc_valid <= exc;
    exc_cause <= cause;
    exc_pc    <= pc;
    exc_tval  <= tval;
    mret      <= ret;
  endtask

  task automatic read_csr(input logic [rv64_csr_pkg::CSR_ADDR_W-1:0] addr);
    drive(1'b0, rv64_csr_pkg::CSR_RW, addr, '0, 1'b0, '0, '0, '0, 1'b0); // rdata needs no strobe
  endtask

  task automatic csr_access(input logic [rv64_csr_pkg::CSR_OP_W-1:0] op,
                            input logic [rv64_csr_pkg::CSR_ADDR_W-1:0] addr,
                            input logic [rv64_csr_pkg::XLEN-1:0] src);
    drive(1'b1, op, addr, src, 1'b0, '0, rand64(), '0, 1'b0);
  endtask

  task automatic report_mismatch(input string what, input logic [rv64_csr_pkg::XLEN-1:0] got,
                                 input logic [rv64_csr_pkg::XLEN-1:0] expected);
    $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, expected);
    $display("STATUS: FAIL");
    $fatal(1, "output mismatch");
  endtask

  initial begin
    @(posedge rst_n);
    forever begin
      @(negedge clk);
      exp_mie = sh_mie; // mie_o shows the state before this edge
      csr_model(exp_rdata, exp_redirect, exp_pc);
      assert (csr_rdata === exp_rdata)
        else report_mismatch("csr_rdata_o", csr_rdata, exp_rdata);
      assert (redirect === exp_redirect)
        else report_mismatch("redirect_o", 64'(redirect), 64'(exp_redirect));
      assert (!exp_redirect || redirect_pc === exp_pc)
        else report_mismatch("redirect_pc_o", redirect_pc, exp_pc);
      assert (mie === exp_mie)
        else report_mismatch("mie_o", 64'(mie), 64'(exp_mie));
    end
  end

  initial begin
    #((TEST_CYCLES + 100) * CLK_PERIOD);
    $display("watchdog expired after %0d cycles without the tests finishing", TEST_CYCLES + 100);
    $display("STATUS: FAIL");
    $fatal(1, "timeout");
  end

  initial begin
    seed      = 32'h7fc1;
    clk       = 1'b0;
    rst_n     = 1'b0;
    csr_valid = 1'b0;
    csr_op    = rv64_csr_pkg::CSR_RW;
    csr_addr  = '0;
    csr_src   = '0;
    exc_valid = 1'b0;
    exc_cause = '0;
    exc_pc    = '0;
    exc_tval  = '0;
    mret      = 1'b0;
    sh_mtvec  = '0;
    sh_mepc   = '0;
    sh_mcause = '0;
    sh_mtval  = '0;
    sh_mie    = 1'b0;
    sh_mpie   = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    read_csr(rv64_csr_pkg::CSR_MSTATUS);
    read_csr(rv64_csr_pkg::CSR_MTVEC);
    read_csr(rv64_csr_pkg::CSR_MEPC);
    read_csr(rv64_csr_pkg::CSR_MCAUSE);
    read_csr(rv64_csr_pkg::CSR_MTVAL);
    read_csr(12'h7c0);

    for (int i = 0; i < N_OPS; i++) begin
      op_sel   = rand_op();
      addr_sel = rand_csr();
      csr_access(op_sel, addr_sel, rand_src(op_sel));
      read_csr(addr_sel);
    end

    // trap entry and mret, with MIE set or cleared beforehand
    for (int i = 0; i < N_TRAPS; i++) begin
      csr_access(rv64_csr_pkg::CSR_RW, rv64_csr_pkg::CSR_MTVEC, rand64());
      rnd    = $random(seed);
      op_sel = rnd[0] ? rv64_csr_pkg::CSR_RSI : rv64_csr_pkg::CSR_RCI;
      csr_access(op_sel, rv64_csr_pkg::CSR_MSTATUS, 64'h8);
      drive(1'b0, rv64_csr_pkg::CSR_RW, '0, '0, 1'b1, rand64(), rand64(), rand64(), 1'b0);
      read_csr(rv64_csr_pkg::CSR_MEPC);
      read_csr(rv64_csr_pkg::CSR_MCAUSE);
      read_csr(rv64_csr_pkg::CSR_MTVAL);
      read_csr(rv64_csr_pkg::CSR_MSTATUS);
      drive(1'b0, rv64_csr_pkg::CSR_RW, '0, '0, 1'b0, '0, '0, '0, 1'b1);
      read_csr(rv64_csr_pkg::CSR_MSTATUS);
    end

    for (int i = 0; i < N_ILLEGAL; i++) begin
      op_sel = rand_op();
      csr_access(op_sel, rand_unimplemented(), rand_src(op_sel));
      read_csr(rv64_csr_pkg::CSR_MCAUSE);
      read_csr(rv64_csr_pkg::CSR_MTVAL);
    end

    // the exception must win over a CSR write presented in the same cycle
    for (int i = 0; i < N_COMBO; i++) begin
      op_sel   = rand_op();
      addr_sel = rand_csr();
      drive(1'b1, op_sel, addr_sel, rand_src(op_sel), 1'b1, rand64(), rand64(), rand64(), 1'b0);
      read_csr(addr_sel);
    end

    read_csr(rv64_csr_pkg::CSR_MSTATUS);
    repeat (2) @(posedge clk);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== hdl/csr_alu.sv ====
`timescale 1ns/100ps

module csr_alu (
  input  logic [rv64_csr_pkg::CSR_OP_W-1:0] csr_op_i,
  input  logic [rv64_csr_pkg::XLEN-1:0]     old_i,
  input  logic [rv64_csr_pkg::XLEN-1:0]     src_i,
  output logic [rv64_csr_pkg::XLEN-1:0]     new_o
);

  logic [rv64_csr_pkg::XLEN-1:0] set_val;
  logic [rv64_csr_pkg::XLEN-1:0] clr_val;

  // the decoder already zero-extends zimm, so immediate forms reuse these paths
  assign set_val = old_i | src_i;
  assign clr_val = old_i & ~src_i;

  always_comb begin
    case (csr_op_i)
      rv64_csr_pkg::CSR_RW,
      rv64_csr_pkg::CSR_RWI: begin
        new_o = src_i;
      end
      rv64_csr_pkg::CSR_RS,
      rv64_csr_pkg::CSR_RSI: begin
        new_o = set_val;
      end
      rv64_csr_pkg::CSR_RC,
      rv64_csr_pkg::CSR_RCI: begin
        new_o = clr_val;
      end
      default: begin
        new_o = old_i; // illegal funct3 leaves the register as it was
      end
    endcase
  end

endmodule

// ==== hdl/rv64_csr_pkg.sv ====
package rv64_csr_pkg;

  localparam int XLEN       = 64;
  localparam int CSR_ADDR_W = 12;

  // machine-mode trap setup and handling registers
  localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC   = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVAL   = 12'h343;

  // funct3 of the SYSTEM opcode
  localparam int CSR_OP_W = 3;

  localparam logic [CSR_OP_W-1:0] CSR_RW  = 3'd1;
  localparam logic [CSR_OP_W-1:0] CSR_RS  = 3'd2;
  localparam logic [CSR_OP_W-1:0] CSR_RC  = 3'd3;
  localparam logic [CSR_OP_W-1:0] CSR_RWI = 3'd5;
  localparam logic [CSR_OP_W-1:0] CSR_RSI = 3'd6;
  localparam logic [CSR_OP_W-1:0] CSR_RCI = 3'd7;

  localparam logic [XLEN-1:0] CAUSE_ILLEGAL_INSN = 64'd2;

  // positions of the two implemented bits inside mstatus
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;

  // mtvec keeps only direct mode, mepc stays halfword aligned
  localparam logic [XLEN-1:0] MTVEC_WMASK = ~64'h3;
  localparam logic [XLEN-1:0] MEPC_WMASK  = ~64'h1;

  // only the interrupt enable stack of mstatus is kept
  typedef struct packed {
    logic mpie;
    logic mie;
  } mstatus_t;

  // legal Zicsr operation codes
  function automatic logic csr_op_legal(input logic [CSR_OP_W-1:0] op);
    case (op)
      CSR_RW, CSR_RS, CSR_RC,
      CSR_RWI, CSR_RSI, CSR_RCI: csr_op_legal = 1'b1;
      default: csr_op_legal = 1'b0;
    endcase
  endfunction

endpackage

// ==== hdl/rv64_csr_regfile.sv ====
`timescale 1ns/100ps

module rv64_csr_regfile (
  input  logic                                 clk,
  input  logic                                 rst_n_i,
  // generic access port, the read address doubles as write address
  input  logic [rv64_csr_pkg::CSR_ADDR_W-1:0] rd_addr_i,
  output logic [rv64_csr_pkg::XLEN-1:0]       rd_data_o,
  output logic                                 addr_hit_o,
  input  logic                                 csr_we_i,
  input  logic [rv64_csr_pkg::XLEN-1:0]       wr_data_i,
  // dedicated trap ports
  input  logic                                 trap_enter_i,
  input  logic                                 trap_return_i,
  input  logic [rv64_csr_pkg::XLEN-1:0]       trap_epc_i,
  input  logic [rv64_csr_pkg::XLEN-1:0]       trap_cause_i,
  input  logic [rv64_csr_pkg::XLEN-1:0]       trap_tval_i,
  // direct register taps
  output logic [rv64_csr_pkg::XLEN-1:0]       mtvec_o,
  output logic [rv64_csr_pkg::XLEN-1:0]       mepc_o,
  output logic                                 mie_o
);

  rv64_csr_pkg::mstatus_t          mstatus_q;
  logic [rv64_csr_pkg::XLEN-1:0]   mtvec_q;
  logic [rv64_csr_pkg::XLEN-1:0]   mepc_q;
  logic [rv64_csr_pkg::XLEN-1:0]   mcause_q;
  logic [rv64_csr_pkg::XLEN-1:0]   mtval_q;

  logic sel_mstatus;
  logic sel_mtvec;
  logic sel_mepc;
  logic sel_mcause;
  logic sel_mtval;

  logic [rv64_csr_pkg::XLEN-1:0] mstatus_rd;

  // one-hot address decode
  assign sel_mstatus = (rd_addr_i == rv64_csr_pkg::CSR_MSTATUS);
  assign sel_mtvec   = (rd_addr_i == rv64_csr_pkg::CSR_MTVEC);
  assign sel_mepc    = (rd_addr_i == rv64_csr_pkg::CSR_MEPC);
  assign sel_mcause  = (rd_addr_i == rv64_csr_pkg::CSR_MCAUSE);
  assign sel_mtval   = (rd_addr_i == rv64_csr_pkg::CSR_MTVAL);

  assign addr_hit_o = sel_mstatus | sel_mtvec | sel_mepc | sel_mcause | sel_mtval;

  always_comb begin
    mstatus_rd = '0;
    mstatus_rd[rv64_csr_pkg::MSTATUS_MIE_BIT]  = mstatus_q.mie;
    mstatus_rd[rv64_csr_pkg::MSTATUS_MPIE_BIT] = mstatus_q.mpie;
  end

  always_comb begin
    rd_data_o = '0; // unimplemented addresses read as zero
    if (sel_mstatus) rd_data_o = mstatus_rd;
    if (sel_mtvec)   rd_data_o = mtvec_q;
    if (sel_mepc)    rd_data_o = mepc_q;
    if (sel_mcause)  rd_data_o = mcause_q;
    if (sel_mtval)   rd_data_o = mtval_q;
  end

  // mstatus interrupt enable stack
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mstatus_q <= '0;
    end else if (trap_enter_i) begin
      mstatus_q.mpie <= mstatus_q.mie;
      mstatus_q.mie  <= 1'b0;
    end else if (trap_return_i) begin
      mstatus_q.mie  <= mstatus_q.mpie;
      mstatus_q.mpie <= 1'b1;
    end else if (csr_we_i && sel_mstatus) begin
      mstatus_q.mie  <= wr_data_i[rv64_csr_pkg::MSTATUS_MIE_BIT];
      mstatus_q.mpie <= wr_data_i[rv64_csr_pkg::MSTATUS_MPIE_BIT];
    end
  end

  // trap writes win over the generic port
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mepc_q   <= '0;
      mcause_q <= '0;
      mtval_q  <= '0;
    end else if (trap_enter_i) begin
      mepc_q   <= trap_epc_i;
      mcause_q <= trap_cause_i;
      mtval_q  <= trap_tval_i;
    end else if (csr_we_i) begin
      if (sel_mepc)   mepc_q   <= wr_data_i & rv64_csr_pkg::MEPC_WMASK;
      if (sel_mcause) mcause_q <= wr_data_i;
      if (sel_mtval)  mtval_q  <= wr_data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtvec_q <= '0;
    end else if (csr_we_i && sel_mtvec && !trap_enter_i) begin
      mtvec_q <= wr_data_i & rv64_csr_pkg::MTVEC_WMASK; // direct mode only
    end
  end

  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;
  assign mie_o   = mstatus_q.mie;

  // trap_ctrl must only commit to a decoded register
  assert property (@(posedge clk) disable iff (!rst_n_i) csr_we_i |-> addr_hit_o)
    else $error("generic CSR write to unimplemented address %h", rd_addr_i);

  assert property (@(posedge clk) disable iff (!rst_n_i) !(trap_enter_i && trap_return_i))
    else $error("trap entry and mret in the same cycle");

endmodule

// ==== hdl/rv64_csr_unit.sv ====
`timescale 1ns/100ps

module rv64_csr_unit (
  input  logic                                 clk,
  input  logic                                 rst_n_i,
  // CSR instruction
  input  logic                                 csr_valid_i,
  input  logic [rv64_csr_pkg::CSR_OP_W-1:0]   csr_op_i,
  input  logic [rv64_csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [rv64_csr_pkg::XLEN-1:0]       csr_src_i,
  // synchronous exception
  input  logic                                 exc_valid_i,
  input  logic [rv64_csr_pkg::XLEN-1:0]       exc_cause_i,
  input  logic [rv64_csr_pkg::XLEN-1:0]       exc_pc_i,
  input  logic [rv64_csr_pkg::XLEN-1:0]       exc_tval_i,
  input  logic                                 mret_i,
  output logic [rv64_csr_pkg::XLEN-1:0]       csr_rdata_o,
  output logic                                 redirect_o,
  output logic [rv64_csr_pkg::XLEN-1:0]       redirect_pc_o,
  output logic                                 mie_o
);

  logic [rv64_csr_pkg::XLEN-1:0] rd_data;
  logic [rv64_csr_pkg::XLEN-1:0] wr_data;
  logic                          addr_hit;
  logic                          csr_we;
  logic                          trap_enter;
  logic                          trap_return;
  logic [rv64_csr_pkg::XLEN-1:0] trap_epc;
  logic [rv64_csr_pkg::XLEN-1:0] trap_cause;
  logic [rv64_csr_pkg::XLEN-1:0] trap_tval;
  logic [rv64_csr_pkg::XLEN-1:0] mtvec;
  logic [rv64_csr_pkg::XLEN-1:0] mepc;

  assign csr_rdata_o = rd_data; // old value goes to rd

  rv64_csr_regfile u_regfile (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .rd_addr_i     (csr_addr_i),
    .rd_data_o     (rd_data),
    .addr_hit_o    (addr_hit),
    .csr_we_i      (csr_we),
    .wr_data_i     (wr_data),
    .trap_enter_i  (trap_enter),
    .trap_return_i (trap_return),
    .trap_epc_i    (trap_epc),
    .trap_cause_i  (trap_cause),
    .trap_tval_i   (trap_tval),
    .mtvec_o       (mtvec),
    .mepc_o        (mepc),
    .mie_o         (mie_o)
  );

  csr_alu u_alu (
    .csr_op_i (csr_op_i),
    .old_i    (rd_data),
    .src_i    (csr_src_i),
    .new_o    (wr_data)
  );

  trap_ctrl u_trap_ctrl (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .csr_valid_i   (csr_valid_i),
    .addr_hit_i    (addr_hit),
    .csr_addr_i    (csr_addr_i),
    .exc_valid_i   (exc_valid_i),
    .exc_cause_i   (exc_cause_i),
    .exc_pc_i      (exc_pc_i),
    .exc_tval_i    (exc_tval_i),
    .mret_i        (mret_i),
    .mtvec_i       (mtvec),
    .mepc_i        (mepc),
    .csr_we_o      (csr_we),
    .trap_enter_o  (trap_enter),
    .trap_return_o (trap_return),
    .trap_epc_o    (trap_epc),
    .trap_cause_o  (trap_cause),
    .trap_tval_o   (trap_tval),
    .redirect_o    (redirect_o),
    .redirect_pc_o (redirect_pc_o)
  );

  // the ALU has no strobe of its own, so its op is checked here against csr_valid_i
  assert property (@(posedge clk) disable iff (!rst_n_i)
                   csr_valid_i |-> rv64_csr_pkg::csr_op_legal(csr_op_i))
    else $error("illegal CSR op %0d", csr_op_i);

endmodule

// ==== hdl/trap_ctrl.sv ====
`timescale 1ns/100ps

module trap_ctrl (
  input  logic                                 clk,
  input  logic                                 rst_n_i,
  input  logic                                 csr_valid_i,
  input  logic                                 addr_hit_i,
  input  logic [rv64_csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
  input  logic                                 exc_valid_i,
  input  logic [rv64_csr_pkg::XLEN-1:0]       exc_cause_i,
  input  logic [rv64_csr_pkg::XLEN-1:0]       exc_pc_i,
  input  logic [rv64_csr_pkg::XLEN-1:0]       exc_tval_i,
  input  logic                                 mret_i,
  input  logic [rv64_csr_pkg::XLEN-1:0]       mtvec_i,
  input  logic [rv64_csr_pkg::XLEN-1:0]       mepc_i,
  output logic                                 csr_we_o,
  output logic                                 trap_enter_o,
  output logic                                 trap_return_o,
  output logic [rv64_csr_pkg::XLEN-1:0]       trap_epc_o,
  output logic [rv64_csr_pkg::XLEN-1:0]       trap_cause_o,
  output logic [rv64_csr_pkg::XLEN-1:0]       trap_tval_o,
  output logic                                 redirect_o,
  output logic [rv64_csr_pkg::XLEN-1:0]       redirect_pc_o
);

  logic illegal;
  logic take_trap;

  assign illegal   = csr_valid_i & ~addr_hit_i;
  assign take_trap = exc_valid_i | illegal;

  // exception > illegal CSR access > mret > CSR commit
  assign trap_enter_o  = take_trap;
  assign trap_return_o = ~take_trap & mret_i;
  assign csr_we_o      = ~take_trap & ~mret_i & csr_valid_i;

  // the pipeline presents the instruction pc on exc_pc_i for CSR ops too
  assign trap_epc_o = exc_pc_i;

  always_comb begin
    if (exc_valid_i) begin
      trap_cause_o = exc_cause_i;
      trap_tval_o  = exc_tval_i;
    end else begin
      trap_cause_o = rv64_csr_pkg::CAUSE_ILLEGAL_INSN;
      trap_tval_o  = {{(rv64_csr_pkg::XLEN - rv64_csr_pkg::CSR_ADDR_W){1'b0}}, csr_addr_i};
    end
  end

  // targets come from the register values before this edge
  always_comb begin
    redirect_o    = 1'b0;
    redirect_pc_o = '0;
    if (take_trap) begin
      redirect_o    = 1'b1;
      redirect_pc_o = mtvec_i;
    end else if (mret_i) begin
      redirect_o    = 1'b1;
      redirect_pc_o = mepc_i;
    end
  end

  // the pipeline cannot retire mret while raising an exception
  assert property (@(posedge clk) disable iff (!rst_n_i) !(exc_valid_i && mret_i))
    else $error("exception and mret presented together");

endmodule

// ==== run_sim.sh ====
#!/bin/bash
# build the CSR unit testbench with Verilator and run it, the exit status carries the result
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f vlog.f --top-module tb_csr_unit -Mdir obj_dir \
  && ./obj_dir/Vtb_csr_unit \
  || { echo "simulation did not pass"; exit 1; }

// ==== vlog.f ====
hdl/rv64_csr_pkg.sv
hdl/rv64_csr_regfile.sv
hdl/csr_alu.sv
hdl/trap_ctrl.sv
hdl/rv64_csr_unit.sv
bench/tb_csr_unit.sv
